// ==== include/cpu_params.svh ====
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// Width of a datapath word.
`define DATA_WIDTH 16

// Eight architectural registers need a 3-bit index.
`define REG_IDX_WIDTH 3

`define OPCODE_WIDTH 4

// CALL saves the return address in this register.
`define LINK_REG 7

`endif

// ==== rtl/isaPkg.sv ====
`include "cpu_params.svh"

package isaPkg;

    // Primary opcodes. The mode bit refines LoadByte and the branches.
    typedef enum logic [`OPCODE_WIDTH-1:0] {
        opAnd            = 0,
        opAdd            = 1,
        opSub            = 2,
        opAddi           = 3,
        opAndi           = 4,
        opLw             = 5,
        opLoadByte       = 6,
        opSw             = 7,
        opBranchGreater  = 8,
        opBranchLess     = 9,
        opBranchEqual    = 10,
        opBranchNotEqual = 11,
        opJmp            = 12,
        opCall           = 13,
        opRet            = 14,
        opSv             = 15
    } opcodeT;

    // Index into the register file.
    typedef logic [`REG_IDX_WIDTH-1:0] regIdxT;

endpackage

// ==== rtl/ctrlPkg.sv ====
package ctrlPkg;

    // Operation performed by the ALU in the execute stage.
    typedef enum logic [1:0] {
        aluAnd = 2'd0,
        aluAdd = 2'd1,
        aluSub = 2'd2
    } aluOpT;

    // Value written back to the register file.
    typedef enum logic [1:0] {
        wbPcLink = 2'd0,
        wbAlu    = 2'd1,
        wbMem    = 2'd2
    } wbSelT;

    // Size and extension of a memory load.
    typedef enum logic [1:0] {
        bytesWord     = 2'd0,
        bytesSigned   = 2'd1,
        bytesUnsigned = 2'd2
    } byteCountT;

    // Source of the next PC.
    typedef enum logic [1:0] {
        pcNext   = 2'd0,
        pcJump   = 2'd1,
        pcBranch = 2'd2,
        pcReturn = 2'd3
    } pcSrcT;

    // Where a decode-stage operand is taken from.
    typedef enum logic [1:0] {
        fwdNone = 2'd0,
        fwdEx   = 2'd1,
        fwdMem  = 2'd2,
        fwdWb   = 2'd3
    } fwdSelT;

endpackage

// ==== rtl/mainAluControl.sv ====
`timescale 1ns/1ps

module mainAluControl (
    input  isaPkg::opcodeT      opCode,
    input  logic                mode,
    input  logic                stall,
    output logic                src1,
    output logic                src2,
    output logic                regDst,
    output logic                extOp,
    output logic                extPlace,
    output logic                aluSrc,
    output ctrlPkg::aluOpT      aluOp,
    output logic                dataInSrc,
    output logic                memRd,
    output logic                memWr,
    output ctrlPkg::byteCountT  numOfByte,
    output ctrlPkg::wbSelT      wbData,
    output logic                regWr
);

    import isaPkg::*;
    import ctrlPkg::*;

    always_comb begin
        // Everything starts inactive, so a stall leaves a clean bubble.
        src1      = 1'b0;
        src2      = 1'b0;
        regDst    = 1'b0;
        extOp     = 1'b0;
        extPlace  = 1'b0;
        aluSrc    = 1'b0;
        aluOp     = aluAnd;
        dataInSrc = 1'b0;
        memRd     = 1'b0;
        memWr     = 1'b0;
        numOfByte = bytesWord;
        wbData    = wbPcLink;
        regWr     = 1'b0;

        if (!stall) begin
            case (opCode)
                opAnd, opAdd, opSub: begin
                    src2   = 1'b1;
                    aluOp  = (opCode == opSub) ? aluSub :
                             (opCode == opAdd) ? aluAdd : aluAnd;
                    wbData = wbAlu;
                    regWr  = 1'b1;
                end
                opAddi, opAndi: begin
                    extOp  = 1'b1;
                    aluSrc = 1'b1;
                    aluOp  = (opCode == opAddi) ? aluAdd : aluAnd;
                    wbData = wbAlu;
                    regWr  = 1'b1;
                end
                opLw, opLoadByte: begin
                    extOp  = 1'b1;
                    aluSrc = 1'b1;
                    aluOp  = aluAdd;
                    memRd  = 1'b1;
                    wbData = wbMem;
                    regWr  = 1'b1;
                    // Mode picks zero extension for byte loads.
                    if (opCode == opLoadByte) begin
                        numOfByte = mode ? bytesUnsigned : bytesSigned;
                    end
                end
                opSw: begin
                    extOp     = 1'b1;
                    aluSrc    = 1'b1;
                    aluOp     = aluAdd;
                    dataInSrc = 1'b1;
                    memWr     = 1'b1;
                end
                opBranchGreater, opBranchLess, opBranchEqual, opBranchNotEqual: begin
                    extOp = 1'b1;
                    src1  = mode;
                end
                opCall: begin
                    regDst = 1'b1;
                    wbData = wbPcLink;
                    regWr  = 1'b1;
                end
                opSv: begin
                    src1     = 1'b1;
                    extPlace = 1'b1;
                    aluOp    = aluAdd;
                    memWr    = 1'b1;
                end
                // JMP and RET only redirect the PC.
                default: begin
                end
            endcase
        end
    end

    // The data memory port cannot read and write in one access.
    always_comb begin
        assert final (!(memRd && memWr))
            else $error("memRd and memWr both set for opcode %0d", opCode);
    end

endmodule

// ==== rtl/pcControl.sv ====
`timescale 1ns/1ps

module pcControl (
    input  isaPkg::opcodeT  opCode,
    input  logic            gt,
    input  logic            lt,
    input  logic            eq,
    output ctrlPkg::pcSrcT  pcSrc,
    output logic            kill
);

    import isaPkg::*;
    import ctrlPkg::*;

    logic taken;

    // Branches resolve in decode, so the flags must be valid this cycle.
    always_comb begin
        case (opCode)
            opBranchGreater:  taken = gt;
            opBranchLess:     taken = lt;
            opBranchEqual:    taken = eq;
            opBranchNotEqual: taken = !eq;
            default:          taken = 1'b0;
        endcase
    end

    always_comb begin
        if (taken) begin
            pcSrc = pcBranch;
            kill  = 1'b1;
        end else if (opCode == opJmp) begin
            pcSrc = pcJump;
            kill  = 1'b1;
        end else if (opCode == opRet) begin
            pcSrc = pcReturn;
            kill  = 1'b1;
        end else begin
            pcSrc = pcNext;
            kill  = 1'b0;
        end
    end

    // Any redirect must flush the instruction already fetched.
    always_comb begin
        assert final (kill == (pcSrc != pcNext))
            else $error("kill %0b disagrees with pcSrc %s", kill, pcSrc.name());
    end

endmodule

// ==== rtl/hazardDetect.sv ====
`timescale 1ns/1ps

module hazardDetect (
    input  isaPkg::regIdxT   rs1,
    input  isaPkg::regIdxT   rs2,
    input  isaPkg::regIdxT   exDest,
    input  isaPkg::regIdxT   memDest,
    input  isaPkg::regIdxT   wbDest,
    input  logic             exRegWr,
    input  logic             memRegWr,
    input  logic             wbRegWr,
    input  logic             exMemRd,
    output ctrlPkg::fwdSelT  forwardA,
    output ctrlPkg::fwdSelT  forwardB,
    output logic             stall
);

    import isaPkg::*;
    import ctrlPkg::*;

    // Nearest writer wins, since it holds the youngest value.
    function automatic fwdSelT pickForward(input regIdxT src);
        fwdSelT sel;

        if (src == '0) begin
            // Register 0 is hardwired and is never forwarded.
            sel = fwdNone;
        end else if (exRegWr && (src == exDest)) begin
            sel = fwdEx;
        end else if (memRegWr && (src == memDest)) begin
            sel = fwdMem;
        end else if (wbRegWr && (src == wbDest)) begin
            sel = fwdWb;
        end else begin
            sel = fwdNone;
        end
        return sel;
    endfunction

    always_comb begin
        forwardA = pickForward(rs1);
        forwardB = pickForward(rs2);
    end

    // A load in execute has no data until the memory stage, one cycle too
    // late for an instruction that needs it right now.
    always_comb begin
        stall = exMemRd && ((forwardA == fwdEx) || (forwardB == fwdEx));
    end

endmodule

// ==== rtl/controlPipe.sv ====
`timescale 1ns/1ps

`include "cpu_params.svh"

module controlPipe (
    input  logic                clk,
    input  logic                reset,
    input  logic                idSrc1,
    input  logic                idSrc2,
    input  logic                idRegDst,
    input  logic                idExtOp,
    input  logic                idExtPlace,
    input  logic                idAluSrc,
    input  ctrlPkg::aluOpT      idAluOp,
    input  logic                idDataInSrc,
    input  logic                idMemRd,
    input  logic                idMemWr,
    input  ctrlPkg::byteCountT  idNumOfByte,
    input  ctrlPkg::wbSelT      idWbData,
    input  logic                idRegWr,
    input  isaPkg::regIdxT      rd,
    output logic                exSrc1,
    output logic                exSrc2,
    output logic                exExtOp,
    output logic                exExtPlace,
    output logic                exAluSrc,
    output ctrlPkg::aluOpT      exAluOp,
    output logic                exMemRd,
    output logic                exRegWr,
    output isaPkg::regIdxT      exDest,
    output logic                memDataInSrc,
    output logic                memRd,
    output logic                memWr,
    output ctrlPkg::byteCountT  memNumOfByte,
    output logic                memRegWr,
    output isaPkg::regIdxT      memDest,
    output ctrlPkg::wbSelT      wbData,
    output logic                wbRegWr,
    output isaPkg::regIdxT      wbDest
);

    import isaPkg::*;
    import ctrlPkg::*;

    regIdxT     idDest;
    logic       exDataInSrc;
    logic       exMemWr;
    byteCountT  exNumOfByte;
    wbSelT      exWbData;
    wbSelT      memWbData;

    // CALL writes the link register instead of rd.
    assign idDest = idRegDst ? regIdxT'(`LINK_REG) : rd;

    always_ff @(posedge clk) begin
        if (reset) begin
            exSrc1       <= 1'b0;
            exSrc2       <= 1'b0;
            exExtOp      <= 1'b0;
            exExtPlace   <= 1'b0;
            exAluSrc     <= 1'b0;
            exAluOp      <= aluAnd;
            exDataInSrc  <= 1'b0;
            exMemRd      <= 1'b0;
            exMemWr      <= 1'b0;
            exNumOfByte  <= bytesWord;
            exWbData     <= wbPcLink;
            exRegWr      <= 1'b0;
            exDest       <= '0;
            memDataInSrc <= 1'b0;
            memRd        <= 1'b0;
            memWr        <= 1'b0;
            memNumOfByte <= bytesWord;
            memWbData    <= wbPcLink;
            memRegWr     <= 1'b0;
            memDest      <= '0;
            wbData       <= wbPcLink;
            wbRegWr      <= 1'b0;
            wbDest       <= '0;
        end else begin
            // ID/EX keeps everything still needed downstream.
            exSrc1       <= idSrc1;
            exSrc2       <= idSrc2;
            exExtOp      <= idExtOp;
            exExtPlace   <= idExtPlace;
            exAluSrc     <= idAluSrc;
            exAluOp      <= idAluOp;
            exDataInSrc  <= idDataInSrc;
            exMemRd      <= idMemRd;
            exMemWr      <= idMemWr;
            exNumOfByte  <= idNumOfByte;
            exWbData     <= idWbData;
            exRegWr      <= idRegWr;
            exDest       <= idDest;
            // ALU fields are dropped after execute.
            memDataInSrc <= exDataInSrc;
            memRd        <= exMemRd;
            memWr        <= exMemWr;
            memNumOfByte <= exNumOfByte;
            memWbData    <= exWbData;
            memRegWr     <= exRegWr;
            memDest      <= exDest;
            wbData       <= memWbData;
            wbRegWr      <= memRegWr;
            wbDest       <= memDest;
        end
    end

    // No register write may leak out of the last stage right after reset.
    assert property (@(posedge clk) reset |=> !wbRegWr)
        else $error("wbRegWr set in the cycle after reset");

endmodule

// ==== rtl/pipelineControl.sv ====
`timescale 1ns/1ps

module pipelineControl (
    input  logic                clk,
    input  logic                reset,
    input  isaPkg::opcodeT      opCode,
    input  logic                mode,
    input  isaPkg::regIdxT      rs1,
    input  isaPkg::regIdxT      rs2,
    input  isaPkg::regIdxT      rd,
    input  logic                gt,
    input  logic                lt,
    input  logic                eq,
    output logic                exSrc1,
    output logic                exSrc2,
    output logic                exExtOp,
    output logic                exExtPlace,
    output logic                exAluSrc,
    output ctrlPkg::aluOpT      exAluOp,
    output logic                exMemRd,
    output logic                exRegWr,
    output isaPkg::regIdxT      exDest,
    output logic                memDataInSrc,
    output logic                memRd,
    output logic                memWr,
    output ctrlPkg::byteCountT  memNumOfByte,
    output logic                memRegWr,
    output isaPkg::regIdxT      memDest,
    output ctrlPkg::wbSelT      wbData,
    output logic                wbRegWr,
    output isaPkg::regIdxT      wbDest,
    output ctrlPkg::fwdSelT     forwardA,
    output ctrlPkg::fwdSelT     forwardB,
    output logic                stall,
    output ctrlPkg::pcSrcT      pcSrc,
    output logic                kill
);

    import ctrlPkg::*;

    // Decode-stage control word.
    logic       idSrc1;
    logic       idSrc2;
    logic       idRegDst;
    logic       idExtOp;
    logic       idExtPlace;
    logic       idAluSrc;
    aluOpT      idAluOp;
    logic       idDataInSrc;
    logic       idMemRd;
    logic       idMemWr;
    byteCountT  idNumOfByte;
    wbSelT      idWbData;
    logic       idRegWr;

    mainAluControl uDecode (
        .opCode(opCode), .mode(mode), .stall(stall),
        .src1(idSrc1), .src2(idSrc2), .regDst(idRegDst), .extOp(idExtOp),
        .extPlace(idExtPlace), .aluSrc(idAluSrc), .aluOp(idAluOp),
        .dataInSrc(idDataInSrc), .memRd(idMemRd), .memWr(idMemWr),
        .numOfByte(idNumOfByte), .wbData(idWbData), .regWr(idRegWr)
    );

    pcControl uPcControl (
        .opCode(opCode), .gt(gt), .lt(lt), .eq(eq), .pcSrc(pcSrc), .kill(kill)
    );

    hazardDetect uHazard (
        .rs1(rs1), .rs2(rs2), .exDest(exDest), .memDest(memDest), .wbDest(wbDest),
        .exRegWr(exRegWr), .memRegWr(memRegWr), .wbRegWr(wbRegWr), .exMemRd(exMemRd),
        .forwardA(forwardA), .forwardB(forwardB), .stall(stall)
    );

    controlPipe uPipe (
        .clk(clk), .reset(reset),
        .idSrc1(idSrc1), .idSrc2(idSrc2), .idRegDst(idRegDst), .idExtOp(idExtOp),
        .idExtPlace(idExtPlace), .idAluSrc(idAluSrc), .idAluOp(idAluOp),
        .idDataInSrc(idDataInSrc), .idMemRd(idMemRd), .idMemWr(idMemWr),
        .idNumOfByte(idNumOfByte), .idWbData(idWbData), .idRegWr(idRegWr), .rd(rd),
        .exSrc1(exSrc1), .exSrc2(exSrc2), .exExtOp(exExtOp), .exExtPlace(exExtPlace),
        .exAluSrc(exAluSrc), .exAluOp(exAluOp), .exMemRd(exMemRd), .exRegWr(exRegWr),
        .exDest(exDest), .memDataInSrc(memDataInSrc), .memRd(memRd), .memWr(memWr),
        .memNumOfByte(memNumOfByte), .memRegWr(memRegWr), .memDest(memDest),
        .wbData(wbData), .wbRegWr(wbRegWr), .wbDest(wbDest)
    );

endmodule

// ==== verif/clockGen.sv ====
`timescale 1ns/1ps

module clockGen (
    output logic clk,
    output logic reset
);

    // 4 ns period.
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Reset covers four rising edges and drops on a falling edge.
    initial begin
        reset = 1'b1;
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

// ==== verif/tbPipelineControl.sv ====
`timescale 1ns/1ps

`include "cpu_params.svh"

module tbPipelineControl;

    import isaPkg::*;
    import ctrlPkg::*;

    typedef struct packed {
        logic       src1, src2, regDst, extOp, extPlace, aluSrc;
        logic [1:0] aluOp;
        logic       dataInSrc, memRd, memWr;
        logic [1:0] numOfByte, wbData;
        logic       regWr;
        regIdxT     dest;
    } ctrlWordT;

    localparam int RandomCycles = 300;
    // Reset, opcode sweep, directed hazards, random part and drain.
    localparam int PlannedCycles = 4 + 256 + 18 + RandomCycles + 4;
    localparam int TimeoutCycles = PlannedCycles * 3 / 2;
    localparam int NumChecks = 23;

    // The columns are src1 src2 regDst extOp extPlace aluSrc _ aluOp _ dataInSrc memRd memWr
    // _ numOfByte _ wbData _ regWr. Mode dependent bits are patched in decodeWord.
    localparam logic [15:0] DecodeTable [16] = '{
        16'b010000_00_000_00_01_1,   // AND
        16'b010000_01_000_00_01_1,   // ADD
        16'b010000_10_000_00_01_1,   // SUB
        16'b000101_01_000_00_01_1,   // ADDI
        16'b000101_00_000_00_01_1,   // ANDI
        16'b000101_01_010_00_10_1,   // LW
        16'b000101_01_010_00_10_1,   // LB
        16'b000101_01_101_00_00_0,   // SW
        16'b000100_00_000_00_00_0,   // BGT
        16'b000100_00_000_00_00_0,   // BLT
        16'b000100_00_000_00_00_0,   // BEQ
        16'b000100_00_000_00_00_0,   // BNE
        16'b000000_00_000_00_00_0,   // JMP
        16'b001000_00_000_00_00_1,   // CALL
        16'b000000_00_000_00_00_0,   // RET
        16'b100010_01_001_00_00_0    // SV
    };

    logic       clk, reset;
    opcodeT     opCode;
    logic       mode, gt, lt, eq;
    regIdxT     rs1, rs2, rd;
    logic       exSrc1, exSrc2, exExtOp, exExtPlace, exAluSrc, exMemRd, exRegWr;
    aluOpT      exAluOp;
    regIdxT     exDest, memDest, wbDest;
    logic       memDataInSrc, memRd, memWr, memRegWr, wbRegWr, stall, kill;
    byteCountT  memNumOfByte;
    wbSelT      wbData;
    fwdSelT     forwardA, forwardB;
    pcSrcT      pcSrc;

    ctrlWordT   modelEx, modelMem, modelWb;
    logic [1:0] expFwdA, expFwdB, expPcSrc;
    logic       expStall, branchTaken;
    logic [2:0] expVals [NumChecks];
    logic [2:0] actVals [NumChecks];
    int         valueErrors = 0;
    int         ruleErrors = 0;
    int         cycleCount = 0;

    string checkNames [NumChecks] = '{
        "exSrc1", "exSrc2", "exExtOp", "exExtPlace", "exAluSrc", "exAluOp", "exMemRd",
        "exRegWr", "exDest", "memDataInSrc", "memRd", "memWr", "memNumOfByte", "memRegWr",
        "memDest", "wbData", "wbRegWr", "wbDest", "forwardA", "forwardB", "stall", "pcSrc",
        "kill"
    };

    clockGen clockSource (.clk(clk), .reset(reset));

    pipelineControl UUT (.*);

    function automatic ctrlWordT decodeWord(input opcodeT op, input logic m, input regIdxT d);
        ctrlWordT w;

        w = ctrlWordT'({DecodeTable[op], d});
        if (op == opLoadByte) begin
            w.numOfByte = m ? 2'd2 : 2'd1;
        end
        if (op >= opBranchGreater && op <= opBranchNotEqual) begin
            w.src1 = m;
        end
        if (w.regDst) begin
            w.dest = regIdxT'(`LINK_REG);
        end
        return w;
    endfunction

    // Youngest writer first. Register 0 never forwards.
    function automatic logic [1:0] nearestWriter(input regIdxT src, input ctrlWordT ex,
                                                 input ctrlWordT mem, input ctrlWordT wb);
        if (src == 3'd0) begin
            return 2'd0;
        end else if (ex.regWr && ex.dest == src) begin
            return 2'd1;
        end else if (mem.regWr && mem.dest == src) begin
            return 2'd2;
        end else if (wb.regWr && wb.dest == src) begin
            return 2'd3;
        end
        return 2'd0;
    endfunction

    always_comb begin
        expFwdA = nearestWriter(rs1, modelEx, modelMem, modelWb);
        expFwdB = nearestWriter(rs2, modelEx, modelMem, modelWb);
        expStall = modelEx.memRd && (expFwdA == 2'd1 || expFwdB == 2'd1);
        branchTaken = (opCode == opBranchGreater && gt) || (opCode == opBranchLess && lt) ||
                      (opCode == opBranchEqual && eq) || (opCode == opBranchNotEqual && !eq);
        expPcSrc = branchTaken ? 2'd2 : (opCode == opJmp) ? 2'd1 :
                   (opCode == opRet) ? 2'd3 : 2'd0;
        expVals = '{modelEx.src1, modelEx.src2, modelEx.extOp, modelEx.extPlace,
                    modelEx.aluSrc, modelEx.aluOp, modelEx.memRd, modelEx.regWr, modelEx.dest,
                    modelMem.dataInSrc, modelMem.memRd, modelMem.memWr, modelMem.numOfByte,
                    modelMem.regWr, modelMem.dest, modelWb.wbData, modelWb.regWr,
                    modelWb.dest, expFwdA, expFwdB, expStall, expPcSrc, expPcSrc != 2'd0};
        actVals = '{exSrc1, exSrc2, exExtOp, exExtPlace, exAluSrc, exAluOp, exMemRd, exRegWr,
                    exDest, memDataInSrc, memRd, memWr, memNumOfByte, memRegWr, memDest,
                    wbData, wbRegWr, wbDest, forwardA, forwardB, stall, pcSrc, kill};
    end

    always @(posedge clk) begin
        if (reset) begin
            modelEx  <= '0;
            modelMem <= '0;
            modelWb  <= '0;
        end else begin
            modelWb  <= modelMem;
            modelMem <= modelEx;
            // A bubble clears the control bits, but its destination still follows rd.
            modelEx  <= expStall ? ctrlWordT'({16'd0, rd}) : decodeWord(opCode, mode, rd);
        end
    end

    task automatic reportMismatch(input string name, input logic [2:0] expected,
                                  input logic [2:0] actual);
        valueErrors++;
        $display("FAILED at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
    endtask

    for (genvar i = 0; i < NumChecks; i++) begin : gCheck
        assert property (@(posedge clk) disable iff (reset) expVals[i] == actVals[i])
            else reportMismatch(checkNames[i], $sampled(expVals[i]), $sampled(actVals[i]));
    end

    aBubble: assert property (@(posedge clk) disable iff (reset)
        stall |=> !(exSrc1 || exSrc2 || exExtOp || exExtPlace || exAluSrc || exMemRd ||
                    exRegWr) && exAluOp == aluAnd)
        else begin
            ruleErrors++;
            $display("Execute stage was not cleared after a load-use stall at %0t", $time);
        end

    aResetClear: assert property (@(posedge clk)
        $fell(reset) |-> !(exRegWr || memRegWr || wbRegWr || exMemRd || memRd || memWr))
        else begin
            ruleErrors++;
            $display("A write or read was still active in the pipe after reset at %0t", $time);
        end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TimeoutCycles) begin
            $display("Timeout: the run did not finish within %0d cycles", TimeoutCycles);
            $display("Errors: %0d value mismatches, %0d rule violations", valueErrors,
                     ruleErrors);
            $display("Test failed");
            $finish;
        end
    end

    task automatic driveInputs(input opcodeT op, input logic m, input regIdxT a,
                               input regIdxT b, input regIdxT d, input logic [2:0] flags);
        opCode = op;
        mode = m;
        rs1 = a;
        rs2 = b;
        rd = d;
        {gt, lt, eq} = flags;
    endtask

    task automatic issue(input opcodeT op, input logic m, input regIdxT a, input regIdxT b,
                         input regIdxT d, input logic [2:0] flags);
        @(negedge clk);
        driveInputs(op, m, a, b, d, flags);
    endtask

    initial begin
        void'($urandom(32'h487e_e510));
        driveInputs(opAnd, 1'b0, 3'd0, 3'd0, 3'd0, 3'b000);
        wait (!reset);

        // Every opcode with both modes and all flag combinations.
        for (int op = 0; op < 16; op++) begin
            for (int m = 0; m < 2; m++) begin
                for (int f = 0; f < 8; f++) begin
                    issue(opcodeT'(op), 1'(m), 3'd0, 3'd0, 3'(op), 3'(f));
                end
            end
        end

        // Forwarding from each stage, nearest writer, register 0 and a non-writer.
        issue(opAdd, 1'b0, 3'd0, 3'd0, 3'd3, 3'b000);
        issue(opAddi, 1'b0, 3'd0, 3'd0, 3'd4, 3'b000);
        issue(opAdd, 1'b0, 3'd0, 3'd0, 3'd5, 3'b000);
        issue(opSub, 1'b0, 3'd3, 3'd4, 3'd1, 3'b000);
        issue(opAnd, 1'b0, 3'd5, 3'd0, 3'd2, 3'b000);
        issue(opAddi, 1'b0, 3'd0, 3'd0, 3'd6, 3'b000);
        issue(opAddi, 1'b0, 3'd0, 3'd0, 3'd6, 3'b000);
        issue(opAdd, 1'b0, 3'd6, 3'd6, 3'd0, 3'b000);
        issue(opAdd, 1'b0, 3'd0, 3'd0, 3'd1, 3'b000);
        issue(opJmp, 1'b0, 3'd0, 3'd0, 3'd7, 3'b000);
        issue(opAdd, 1'b0, 3'd7, 3'd7, 3'd1, 3'b000);

        // Load-use; the dependent instruction is held for a second cycle.
        issue(opLw, 1'b0, 3'd0, 3'd0, 3'd3, 3'b000);
        issue(opAdd, 1'b0, 3'd3, 3'd0, 3'd2, 3'b000);
        issue(opAdd, 1'b0, 3'd3, 3'd0, 3'd2, 3'b000);

        issue(opCall, 1'b0, 3'd0, 3'd0, 3'd1, 3'b000);
        repeat (3) issue(opAnd, 1'b0, 3'd0, 3'd0, 3'd0, 3'b000);

        for (int i = 0; i < RandomCycles; i++) begin
            issue(opcodeT'($urandom_range(15)), 1'($urandom), 3'($urandom), 3'($urandom),
                  3'($urandom), 3'($urandom));
        end

        repeat (4) @(negedge clk);
        $display("Errors: %0d value mismatches, %0d rule violations", valueErrors, ruleErrors);
        if (valueErrors + ruleErrors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+include
rtl/isaPkg.sv
rtl/ctrlPkg.sv
rtl/mainAluControl.sv
rtl/pcControl.sv
rtl/hazardDetect.sv
rtl/controlPipe.sv
rtl/pipelineControl.sv
verif/clockGen.sv
verif/tbPipelineControl.sv
